// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    // ------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------
    localparam int OPC_LSB = 26;
    localparam int OPC_W   = 6;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int FN_LSB  = 0;
    localparam int FN_W    = 6;
    localparam int IMM_LSB = 0;
    localparam int IMM_W   = 16;

    // primary opcodes
    localparam logic [OPC_W-1:0] OPC_SPECIAL = 6'h00;
    localparam logic [OPC_W-1:0] OPC_BEQ     = 6'h04;
    localparam logic [OPC_W-1:0] OPC_BNE     = 6'h05;
    localparam logic [OPC_W-1:0] OPC_ADDIU   = 6'h09;
    localparam logic [OPC_W-1:0] OPC_ORI     = 6'h0d;
    localparam logic [OPC_W-1:0] OPC_LUI     = 6'h0f;
    localparam logic [OPC_W-1:0] OPC_SB      = 6'h28;
    localparam logic [OPC_W-1:0] OPC_LW      = 6'h23;
    localparam logic [OPC_W-1:0] OPC_SW      = 6'h2b;

    // function codes under SPECIAL
    localparam logic [FN_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FN_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FN_W-1:0] FN_AND  = 6'h24;
    localparam logic [FN_W-1:0] FN_OR   = 6'h25;
    localparam logic [FN_W-1:0] FN_XOR  = 6'h26;
    localparam logic [FN_W-1:0] FN_SLT  = 6'h2a;

endpackage

// File: cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_WORD,
        ST_BYTE
    } store_kind_e;

    // ------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;
        logic [XLEN-1:0]       store_data;
        store_kind_e           store_kind;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       alu_result;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       wdata;
        logic [REG_ADDR_W-1:0] dest;
    } mem_wb_t;

endpackage

// File: pipe_stage_reg.sv
module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     next_allowin,
    input  logic     ready_go,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_payload
);

    // empty, or the held instruction drains this cycle
    assign allowin = !out_valid || (ready_go && next_allowin);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (allowin) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin && in_valid) begin
            out_payload <= in_payload;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
        else $error("stage valid bit is unknown");

endmodule

// File: fetch_stage.sv
module fetch_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            id_allowin,
    input  logic            br_taken,
    input  logic [XLEN-1:0] br_target,
    input  logic [XLEN-1:0] inst_sram_rdata,
    output logic            inst_sram_en,
    output logic [XLEN-1:0] inst_sram_addr,
    output logic            if_valid,
    output logic [XLEN-1:0] if_pc,
    output logic [XLEN-1:0] if_inst
);

    // pc of the word coming back from the SRAM this cycle
    logic [XLEN-1:0] pc_q;
    logic            valid_q;
    logic [XLEN-1:0] req_addr;

    // re-issue pc_q until decode takes the word
    always_comb begin
        req_addr = pc_q;
        if (valid_q && id_allowin) begin
            req_addr = br_taken ? br_target : pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            valid_q <= 1'b1;
            pc_q    <= req_addr;
        end
    end

    assign inst_sram_en   = 1'b1;
    assign inst_sram_addr = req_addr;
    assign if_valid       = valid_q;
    assign if_pc          = pc_q;
    assign if_inst        = inst_sram_rdata;

    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_sram_addr[1:0] == 2'b00)
        else $error("misaligned fetch address %h", inst_sram_addr);

endmodule

// File: reg_file.sv
module reg_file
    import cpu_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] raddr_a,
    input  logic [REG_ADDR_W-1:0] raddr_b,
    output logic [XLEN-1:0]       rdata_a,
    output logic [XLEN-1:0]       rdata_b,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    // r0 has no storage
    logic [XLEN-1:0] regs [1:REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // writeback drops r0 targets before they reach here
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (waddr != '0))
        else $error("register file write to r0");

endmodule

// File: decode_stage.sv
module decode_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  if_valid,
    input  logic [XLEN-1:0]       if_pc,
    input  logic [XLEN-1:0]       if_inst,
    input  logic                  ex_allowin,
    input  logic [REG_ADDR_W-1:0] exe_dest,
    input  logic [REG_ADDR_W-1:0] mem_dest,
    input  logic [REG_ADDR_W-1:0] wb_dest,
    input  logic                  rf_we,
    input  logic [REG_ADDR_W-1:0] rf_waddr,
    input  logic [XLEN-1:0]       rf_wdata,
    output logic                  id_allowin,
    output logic                  br_taken,
    output logic [XLEN-1:0]       br_target,
    output logic                  id_valid,
    output logic [XLEN-1:0]       id_pc,
    output alu_op_e               id_alu_op,
    output logic [XLEN-1:0]       id_src_a,
    output logic [XLEN-1:0]       id_src_b,
    output logic [XLEN-1:0]       id_store_data,
    output store_kind_e           id_store_kind,
    output wb_sel_e               id_wb_sel,
    output logic [REG_ADDR_W-1:0] id_dest
);

    if_id_t                if_d;
    if_id_t                id_q;
    logic                  id_full;
    logic                  ready_go;
    logic [OPC_W-1:0]      opcode;
    logic [FN_W-1:0]       funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [IMM_W-1:0]      imm;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_val;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic                  use_rs;
    logic                  use_rt;
    logic                  use_imm;
    logic                  is_beq;
    logic                  is_bne;

    function automatic logic reg_busy(input logic [REG_ADDR_W-1:0] r,
                                      input logic [REG_ADDR_W-1:0] e,
                                      input logic [REG_ADDR_W-1:0] m,
                                      input logic [REG_ADDR_W-1:0] w);
        return (r != '0) && (r == e || r == m || r == w);
    endfunction

    assign if_d = '{pc: if_pc, inst: if_inst};

    pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (if_valid),
        .in_payload   (if_d),
        .next_allowin (ex_allowin),
        .ready_go     (ready_go),
        .allowin      (id_allowin),
        .out_valid    (id_full),
        .out_payload  (id_q)
    );

    assign opcode   = id_q.inst[OPC_LSB +: OPC_W];
    assign funct    = id_q.inst[FN_LSB +: FN_W];
    assign rs       = id_q.inst[RS_LSB +: REG_ADDR_W];
    assign rt       = id_q.inst[RT_LSB +: REG_ADDR_W];
    assign rd       = id_q.inst[RD_LSB +: REG_ADDR_W];
    assign imm      = id_q.inst[IMM_LSB +: IMM_W];
    assign imm_sext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (rs),
        .raddr_b (rt),
        .rdata_a (rs_val),
        .rdata_b (rt_val),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    // ------------------------------------------------------------
    // instruction decode
    // ------------------------------------------------------------
    always_comb begin
        id_alu_op     = ALU_ADD;
        id_store_kind = ST_NONE;
        id_wb_sel     = WB_ALU;
        id_dest       = '0;
        use_rs        = 1'b0;
        use_rt        = 1'b0;
        use_imm       = 1'b1;
        imm_val       = imm_sext;
        is_beq        = 1'b0;
        is_bne        = 1'b0;
        case (opcode)
            OPC_SPECIAL: begin
                use_rs  = 1'b1;
                use_rt  = 1'b1;
                use_imm = 1'b0;
                id_dest = rd;
                case (funct)
                    FN_ADDU: id_alu_op = ALU_ADD;
                    FN_SUBU: id_alu_op = ALU_SUB;
                    FN_AND:  id_alu_op = ALU_AND;
                    FN_OR:   id_alu_op = ALU_OR;
                    FN_XOR:  id_alu_op = ALU_XOR;
                    FN_SLT:  id_alu_op = ALU_SLT;
                    default: begin
                        // unsupported function, runs as a no-op
                        use_rs  = 1'b0;
                        use_rt  = 1'b0;
                        id_dest = '0;
                    end
                endcase
            end
            OPC_ADDIU: begin
                use_rs  = 1'b1;
                id_dest = rt;
            end
            OPC_ORI: begin
                use_rs    = 1'b1;
                id_alu_op = ALU_OR;
                imm_val   = {{(XLEN-IMM_W){1'b0}}, imm};
                id_dest   = rt;
            end
            OPC_LUI: begin
                id_alu_op = ALU_LUI;
                imm_val   = {imm, {(XLEN-IMM_W){1'b0}}};
                id_dest   = rt;
            end
            OPC_LW: begin
                use_rs    = 1'b1;
                id_wb_sel = WB_MEM;
                id_dest   = rt;
            end
            OPC_SW, OPC_SB: begin
                use_rs        = 1'b1;
                use_rt        = 1'b1;
                id_store_kind = (opcode == OPC_SW) ? ST_WORD : ST_BYTE;
            end
            OPC_BEQ: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = 1'b1;
            end
            OPC_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_bne = 1'b1;
            end
            default: ;
        endcase
    end

    // interlock until every older writer of a source or dest has retired
    assign ready_go = !((use_rs && reg_busy(rs, exe_dest, mem_dest, wb_dest)) ||
                        (use_rt && reg_busy(rt, exe_dest, mem_dest, wb_dest)) ||
                        reg_busy(id_dest, exe_dest, mem_dest, wb_dest));

    assign id_valid      = id_full && ready_go;
    assign id_pc         = id_q.pc;
    assign id_src_a      = rs_val;
    assign id_src_b      = use_imm ? imm_val : rt_val;
    assign id_store_data = rt_val;

    // target is relative to the delay slot
    assign br_target = id_q.pc + 32'd4 + {imm_sext[XLEN-3:0], 2'b00};
    assign br_taken  = id_valid && ex_allowin &&
                       ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val));

endmodule

// File: execute_stage.sv
module execute_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  id_valid,
    input  logic [XLEN-1:0]       id_pc,
    input  alu_op_e               id_alu_op,
    input  logic [XLEN-1:0]       id_src_a,
    input  logic [XLEN-1:0]       id_src_b,
    input  logic [XLEN-1:0]       id_store_data,
    input  store_kind_e           id_store_kind,
    input  wb_sel_e               id_wb_sel,
    input  logic [REG_ADDR_W-1:0] id_dest,
    input  logic                  mem_allowin,
    output logic                  ex_allowin,
    output logic [REG_ADDR_W-1:0] exe_dest,
    output logic                  data_sram_en,
    output logic [3:0]            data_sram_wen,
    output logic [XLEN-1:0]       data_sram_addr,
    output logic [XLEN-1:0]       data_sram_wdata,
    output logic                  ex_valid,
    output logic [XLEN-1:0]       ex_pc,
    output logic [XLEN-1:0]       ex_result,
    output wb_sel_e               ex_wb_sel,
    output logic [REG_ADDR_W-1:0] ex_dest
);

    id_ex_t ex_d;
    id_ex_t ex_q;
    logic   leaving;

    assign ex_d = '{pc: id_pc, alu_op: id_alu_op, src_a: id_src_a, src_b: id_src_b,
                    store_data: id_store_data, store_kind: id_store_kind,
                    wb_sel: id_wb_sel, dest: id_dest};

    pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (id_valid),
        .in_payload   (ex_d),
        .next_allowin (mem_allowin),
        .ready_go     (1'b1),
        .allowin      (ex_allowin),
        .out_valid    (ex_valid),
        .out_payload  (ex_q)
    );

    always_comb begin
        case (ex_q.alu_op)
            ALU_ADD: ex_result = ex_q.src_a + ex_q.src_b;
            ALU_SUB: ex_result = ex_q.src_a - ex_q.src_b;
            ALU_AND: ex_result = ex_q.src_a & ex_q.src_b;
            ALU_OR:  ex_result = ex_q.src_a | ex_q.src_b;
            ALU_XOR: ex_result = ex_q.src_a ^ ex_q.src_b;
            ALU_SLT: ex_result = {31'b0, $signed(ex_q.src_a) < $signed(ex_q.src_b)};
            ALU_LUI: ex_result = ex_q.src_b;
            default: ex_result = '0;
        endcase
    end

    // ------------------------------------------------------------
    // data SRAM request, issued as the instruction moves on
    // ------------------------------------------------------------
    assign leaving      = ex_valid && mem_allowin;
    assign data_sram_en = leaving && (ex_q.wb_sel == WB_MEM || ex_q.store_kind != ST_NONE);

    always_comb begin
        data_sram_wen = 4'b0000;
        if (leaving) begin
            case (ex_q.store_kind)
                ST_WORD: data_sram_wen = 4'b1111;
                ST_BYTE: data_sram_wen = 4'b0001 << ex_result[1:0];
                default: data_sram_wen = 4'b0000;
            endcase
        end
    end

    assign data_sram_addr  = ex_result;
    assign data_sram_wdata = (ex_q.store_kind == ST_BYTE) ? {4{ex_q.store_data[7:0]}}
                                                          : ex_q.store_data;

    assign exe_dest  = ex_valid ? ex_q.dest : '0;
    assign ex_pc     = ex_q.pc;
    assign ex_wb_sel = ex_q.wb_sel;
    assign ex_dest   = ex_q.dest;

    a_wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        (data_sram_wen != 4'b0000) |-> data_sram_en)
        else $error("byte enables without a data request");

endmodule

// File: mem_wb_stage.sv
module mem_wb_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [XLEN-1:0]       ex_pc,
    input  logic [XLEN-1:0]       ex_result,
    input  wb_sel_e               ex_wb_sel,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic [XLEN-1:0]       data_sram_rdata,
    output logic                  mem_allowin,
    output logic [REG_ADDR_W-1:0] mem_dest,
    output logic [REG_ADDR_W-1:0] wb_dest,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic [XLEN-1:0]       debug_wb_pc,
    output logic                  debug_wb_rf_wen,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]       debug_wb_rf_wdata
);

    ex_mem_t mem_d;
    ex_mem_t mem_q;
    mem_wb_t wb_d;
    mem_wb_t wb_q;
    logic    mem_valid;
    logic    wb_valid;
    logic    wb_allowin;

    assign mem_d = '{pc: ex_pc, alu_result: ex_result, wb_sel: ex_wb_sel, dest: ex_dest};

    pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (ex_valid),
        .in_payload   (mem_d),
        .next_allowin (wb_allowin),
        .ready_go     (1'b1),
        .allowin      (mem_allowin),
        .out_valid    (mem_valid),
        .out_payload  (mem_q)
    );

    // load data is on the bus while the load sits here
    assign wb_d = '{pc: mem_q.pc,
                    wdata: (mem_q.wb_sel == WB_MEM) ? data_sram_rdata : mem_q.alu_result,
                    dest: mem_q.dest};

    pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (mem_valid),
        .in_payload   (wb_d),
        .next_allowin (1'b1),
        .ready_go     (1'b1),
        .allowin      (wb_allowin),
        .out_valid    (wb_valid),
        .out_payload  (wb_q)
    );

    assign mem_dest = mem_valid ? mem_q.dest : '0;
    assign wb_dest  = wb_valid ? wb_q.dest : '0;

    assign rf_we    = wb_valid && (wb_q.dest != '0);
    assign rf_waddr = wb_q.dest;
    assign rf_wdata = wb_q.wdata;

    // trace mirrors the register file write
    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wen   = rf_we;
    assign debug_wb_rf_wnum  = wb_q.dest;
    assign debug_wb_rf_wdata = wb_q.wdata;

endmodule

// File: mips_core.sv
module mips_core
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  inst_sram_en,
    output logic [XLEN-1:0]       inst_sram_addr,
    input  logic [XLEN-1:0]       inst_sram_rdata,
    output logic                  data_sram_en,
    output logic [3:0]            data_sram_wen,
    output logic [XLEN-1:0]       data_sram_addr,
    output logic [XLEN-1:0]       data_sram_wdata,
    input  logic [XLEN-1:0]       data_sram_rdata,
    output logic [XLEN-1:0]       debug_wb_pc,
    output logic                  debug_wb_rf_wen,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]       debug_wb_rf_wdata
);

    // ------------------------------------------------------------
    // fetch to decode
    // ------------------------------------------------------------
    logic                  id_allowin;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;
    logic                  if_valid;
    logic [XLEN-1:0]       if_pc;
    logic [XLEN-1:0]       if_inst;

    // ------------------------------------------------------------
    // decode to execute, plus hazard and writeback feedback
    // ------------------------------------------------------------
    logic                  ex_allowin;
    logic [REG_ADDR_W-1:0] exe_dest;
    logic [REG_ADDR_W-1:0] mem_dest;
    logic [REG_ADDR_W-1:0] wb_dest;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  id_valid;
    logic [XLEN-1:0]       id_pc;
    alu_op_e               id_alu_op;
    logic [XLEN-1:0]       id_src_a;
    logic [XLEN-1:0]       id_src_b;
    logic [XLEN-1:0]       id_store_data;
    store_kind_e           id_store_kind;
    wb_sel_e               id_wb_sel;
    logic [REG_ADDR_W-1:0] id_dest;

    // execute to memory
    logic                  mem_allowin;
    logic                  ex_valid;
    logic [XLEN-1:0]       ex_pc;
    logic [XLEN-1:0]       ex_result;
    wb_sel_e               ex_wb_sel;
    logic [REG_ADDR_W-1:0] ex_dest;

    // port names match the nets above
    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    mem_wb_stage  u_mem_wb  (.*);

endmodule

// File: tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program words, then the expected writeback trace
// trace columns: test id, pc, destination register, written data

localparam int              PROG_LEN  = 38;
localparam int              TRACE_LEN = 27;
localparam logic [XLEN-1:0] NOP_WORD  = 32'h0000_0000;

typedef struct packed {
    logic [2:0]            test_id;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] wnum;
    logic [XLEN-1:0]       wdata;
} trace_row_t;

localparam logic [XLEN-1:0] PROG [PROG_LEN] = '{
    // lui r1,0x1234 / ori r1,r1,0x5678 / addiu r2,r0,0xff0f / addiu r3,r0,5
    32'h3c01_1234, 32'h3421_5678, 32'h2402_ff0f, 32'h2403_0005,
    // addu r4,r2,r3 / subu r5,r3,r2 / and r6,r1,r2 / or r7,r1,r3
    32'h0043_2021, 32'h0062_2823, 32'h0022_3024, 32'h0023_3825,
    // xor r8,r1,r2 / slt r9,r2,r3 / slt r10,r3,r2
    32'h0022_4026, 32'h0043_482a, 32'h0062_502a,
    // addiu r11,r0,1 / addu r11,r11,r11 twice / subu r12,r11,r3 / addiu r12,r12,2
    32'h240b_0001, 32'h016b_5821, 32'h016b_5821, 32'h0163_6023, 32'h258c_0002,
    // sw r1,16(r0) / lw r13,16(r0) / sb r3,18(r0) / lw r14,16(r0)
    32'hac01_0010, 32'h8c0d_0010, 32'ha003_0012, 32'h8c0e_0010,
    // sb r2,15(r3) / lw r15,20(r0)
    32'ha062_000f, 32'h8c0f_0014,
    // beq r3,r3,+2 / addiu r16,r0,0x16 / addiu r17,r0,0xbad which is skipped
    32'h1063_0002, 32'h2410_0016, 32'h2411_0bad,
    // bne r3,r3,+2 / addiu r18,r0,0x18 / addiu r19,r0,0x19
    32'h1463_0002, 32'h2412_0018, 32'h2413_0019,
    // bne r2,r3,+2 / addiu r20,r0,0x20 / addiu r21,r0,0xbad which is skipped
    32'h1443_0002, 32'h2414_0020, 32'h2415_0bad,
    // beq r20,r3,+2 / addiu r22,r0,0x22 / addiu r23,r0,0x23
    32'h1283_0002, 32'h2416_0022, 32'h2417_0023,
    // addiu r0,r0,0x77 / addu r0,r1,r1 / or r24,r0,r0 / addu r25,r0,r3
    32'h2400_0077, 32'h0021_0021, 32'h0000_c025, 32'h0003_c821
};

localparam trace_row_t TRACE [TRACE_LEN] = '{
    '{3'd2, 32'h0000_0000, 5'd1,  32'h1234_0000},
    '{3'd2, 32'h0000_0004, 5'd1,  32'h1234_5678},
    '{3'd2, 32'h0000_0008, 5'd2,  32'hffff_ff0f},
    '{3'd2, 32'h0000_000c, 5'd3,  32'h0000_0005},
    '{3'd2, 32'h0000_0010, 5'd4,  32'hffff_ff14},
    '{3'd2, 32'h0000_0014, 5'd5,  32'h0000_00f6},
    '{3'd2, 32'h0000_0018, 5'd6,  32'h1234_5608},
    '{3'd2, 32'h0000_001c, 5'd7,  32'h1234_567d},
    '{3'd2, 32'h0000_0020, 5'd8,  32'hedcb_a977},
    '{3'd2, 32'h0000_0024, 5'd9,  32'h0000_0001},
    '{3'd2, 32'h0000_0028, 5'd10, 32'h0000_0000},
    '{3'd3, 32'h0000_002c, 5'd11, 32'h0000_0001},
    '{3'd3, 32'h0000_0030, 5'd11, 32'h0000_0002},
    '{3'd3, 32'h0000_0034, 5'd11, 32'h0000_0004},
    '{3'd3, 32'h0000_0038, 5'd12, 32'hffff_ffff},
    '{3'd3, 32'h0000_003c, 5'd12, 32'h0000_0001},
    '{3'd4, 32'h0000_0044, 5'd13, 32'h1234_5678},
    '{3'd4, 32'h0000_004c, 5'd14, 32'h1205_5678},
    '{3'd4, 32'h0000_0054, 5'd15, 32'h0000_000f},
    '{3'd5, 32'h0000_005c, 5'd16, 32'h0000_0016},
    '{3'd5, 32'h0000_0068, 5'd18, 32'h0000_0018},
    '{3'd5, 32'h0000_006c, 5'd19, 32'h0000_0019},
    '{3'd5, 32'h0000_0074, 5'd20, 32'h0000_0020},
    '{3'd5, 32'h0000_0080, 5'd22, 32'h0000_0022},
    '{3'd5, 32'h0000_0084, 5'd23, 32'h0000_0023},
    '{3'd6, 32'h0000_0090, 5'd24, 32'h0000_0000},
    '{3'd6, 32'h0000_0094, 5'd25, 32'h0000_0005}
};

`endif

// File: tb_mips_core.sv
module tb_mips_core
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int ROM_DEPTH      = 256;
    localparam int DRAM_DEPTH     = 256;
    localparam int MEM_IDX_W      = $clog2(ROM_DEPTH);
    localparam int TIMEOUT_MARGIN = 50;
    localparam int DRAIN_CYCLES   = 20;
    localparam int NUM_TESTS      = 6;
    localparam int MEM_TEST       = 4;
    localparam int MEM_STORES     = 3;

    `include "tb_program.svh"

    localparam int CYCLE_LIMIT = 10 * PROG_LEN + TIMEOUT_MARGIN;

    logic                  clk;
    logic                  rst_n = 1'b0;
    logic                  inst_sram_en;
    logic [XLEN-1:0]       inst_sram_addr;
    logic [XLEN-1:0]       inst_sram_rdata = '0;
    logic                  data_sram_en;
    logic [3:0]            data_sram_wen;
    logic [XLEN-1:0]       data_sram_addr;
    logic [XLEN-1:0]       data_sram_wdata;
    logic [XLEN-1:0]       data_sram_rdata = '0;
    logic [XLEN-1:0]       debug_wb_pc;
    logic                  debug_wb_rf_wen;
    logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]       debug_wb_rf_wdata;

    logic [XLEN-1:0] rom  [ROM_DEPTH];
    logic [XLEN-1:0] dram [DRAM_DEPTH] = '{default: '0};

    int tests_passed = 0;
    int tests_failed = 0;
    int test_errs    = 0;
    int store_count  = 0;
    int store_errs   = 0;
    int extra_writes = 0;

    mips_core u_mips_core (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // memory models with one-cycle read latency
    // ------------------------------------------------------------
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = (i < PROG_LEN) ? PROG[i] : NOP_WORD;
        end
    end

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= rom[inst_sram_addr[MEM_IDX_W+1:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= dram[data_sram_addr[MEM_IDX_W+1:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen[b]) begin
                    dram[data_sram_addr[MEM_IDX_W+1:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
        end
    end

    // word stores are aligned and byte stores enable the lane of addr[1:0]
    always @(negedge clk) begin
        if (rst_n && data_sram_en && data_sram_wen != 4'b0000) begin
            store_count++;
            assert ((data_sram_wen == 4'b1111 && data_sram_addr[1:0] == 2'b00) ||
                    data_sram_wen == (4'b0001 << data_sram_addr[1:0]))
            else begin
                $display("FAILED at %0t: store to %h has byte enables %b",
                         $time, data_sram_addr, data_sram_wen);
                store_errs++;
            end
        end
    end

    // ------------------------------------------------------------
    // checks and report
    // ------------------------------------------------------------
    function automatic string test_name(input int id);
        case (id)
            1:       return "reset";
            2:       return "alu";
            3:       return "interlock";
            4:       return "memory";
            5:       return "branch";
            default: return "r0";
        endcase
    endfunction

    task automatic finish_test(input int id);
        if (id == MEM_TEST) begin
            assert (store_count == MEM_STORES)
            else begin
                $display("memory test issued %0d stores instead of %0d",
                         store_count, MEM_STORES);
                test_errs++;
            end
            test_errs += store_errs;
        end
        if (test_errs == 0) begin
            $display("test %0d (%s): passed", id, test_name(id));
            tests_passed++;
        end else begin
            $display("test %0d (%s): failed with %0d errors", id, test_name(id), test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic check_write(input trace_row_t exp_row);
        assert (debug_wb_pc == exp_row.pc && debug_wb_rf_wnum == exp_row.wnum &&
                debug_wb_rf_wdata == exp_row.wdata)
        else begin
            $display("FAILED at %0t: write pc %h r%0d = %h, expected pc %h r%0d = %h",
                     $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                     exp_row.pc, exp_row.wnum, exp_row.wdata);
            test_errs++;
        end
    endtask

    initial begin
        int row;
        int cycles;

        row    = 0;
        cycles = 0;

        // release on the fifth edge and sample once more in the cycle after reset
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            assert (!debug_wb_rf_wen && !data_sram_en)
            else begin
                $display("FAILED at %0t: write or data request active around reset", $time);
                test_errs++;
            end
        end
        assert (inst_sram_addr == RESET_PC)
        else begin
            $display("FAILED at %0t: first fetch address %h, expected %h",
                     $time, inst_sram_addr, RESET_PC);
            test_errs++;
        end
        finish_test(1);

        // walk the trace one row per register write
        while (row < TRACE_LEN && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_wen) begin
                check_write(TRACE[row]);
                if (row == TRACE_LEN - 1 || TRACE[row + 1].test_id != TRACE[row].test_id) begin
                    finish_test(TRACE[row].test_id);
                end
                row++;
            end
        end

        if (row < TRACE_LEN) begin
            $display("timed out after %0d cycles, no write seen for pc %h (row %0d of %0d)",
                     cycles, TRACE[row].pc, row, TRACE_LEN);
            tests_failed += NUM_TESTS - tests_passed - tests_failed;
        end else begin
            // nothing else may write once the trace is done
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                assert (!debug_wb_rf_wen)
                else begin
                    $display("unexpected write to r%0d at pc %h after the last expected write",
                             debug_wb_rf_wnum, debug_wb_pc);
                    extra_writes++;
                end
            end
        end

        $display("%0d tests passed, %0d tests failed, %0d extra writes",
                 tests_passed, tests_failed, extra_writes);
        if (tests_failed == 0 && extra_writes == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
pipe_stage_reg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
mips_core.sv
tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - cpu_isa_pkg.sv
      - cpu_pipe_pkg.sv
      - pipe_stage_reg.sv
      - fetch_stage.sv
      - reg_file.sv
      - decode_stage.sv
      - execute_stage.sv
      - mem_wb_stage.sv
      - mips_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mips_core.sv
